/* hw/cpuCtrlPkg.sv */
package cpuCtrlPkg;

    localparam int instrWidth = 6;
    localparam int modeWidth = 4;
    localparam int stepWidth = 2;   // step number inside one phase
    localparam int numFlags = 32;
    localparam int wbDataWidth = 16;

    // instruction codes, same numbering as the opcode decoder
    localparam logic [instrWidth-1:0]
        instrAdc = 6'd1,   instrAnd = 6'd2,   instrAsl = 6'd3,   instrBcc = 6'd4,
        instrBcs = 6'd5,   instrBeq = 6'd6,   instrBit = 6'd7,   instrBmi = 6'd8,
        instrBne = 6'd9,   instrBpl = 6'd10,  instrBrk = 6'd11,  instrBvc = 6'd12,
        instrBvs = 6'd13,  instrClc = 6'd14,  instrCld = 6'd15,  instrCli = 6'd16,
        instrClv = 6'd17,  instrCmp = 6'd18,  instrCpx = 6'd19,  instrCpy = 6'd20,
        instrDec = 6'd21,  instrDex = 6'd22,  instrDey = 6'd23,  instrEor = 6'd24,
        instrInc = 6'd25,  instrInx = 6'd26,  instrIny = 6'd27,  instrJmp = 6'd28,
        instrJsr = 6'd29,  instrLda = 6'd30,  instrLdx = 6'd31,  instrLdy = 6'd32,
        instrLsr = 6'd33,  instrNop = 6'd34,  instrOra = 6'd35,  instrPha = 6'd36,
        instrPhp = 6'd37,  instrPla = 6'd38,  instrPlp = 6'd39,  instrRol = 6'd40,
        instrRor = 6'd41,  instrRti = 6'd42,  instrRts = 6'd43,  instrSbc = 6'd44,
        instrSec = 6'd45,  instrSed = 6'd46,  instrSei = 6'd47,  instrSta = 6'd48,
        instrSto = 6'd49,  instrStx = 6'd50,  instrSty = 6'd51,  instrTax = 6'd52,
        instrTay = 6'd53,  instrTsx = 6'd54,  instrTxa = 6'd55,  instrTxs = 6'd56,
        instrAslA = 6'd57, instrRolA = 6'd58, instrLsrA = 6'd59, instrRorA = 6'd60,
        instrTya = 6'd61;

    // addressing mode codes
    localparam logic [modeWidth-1:0]
        modeAcc = 4'd0,  modeAbs = 4'd1,  modeAbsX = 4'd2,  modeAbsY = 4'd3,
        modeImm = 4'd4,  modeImpl = 4'd5, modeInd = 4'd6,   modeXind = 4'd7,
        modeIndY = 4'd8, modeRel = 4'd9,  modeZpg = 4'd10,  modeZpgX = 4'd11,
        modeZpgY = 4'd12, modeImplied = 4'd13;

    // bit positions in the control flag vector
    localparam int
        flagPcInc = 0,         flagLoadPc = 1,            flagLoadAbl = 2,
        flagLoadAbh = 3,       flagAdlToPcl = 4,          flagAdhToPch = 5,
        flagAdlToAlu = 6,      flagAdlToData = 7,         flagAdhToData = 8,
        flagAdhToSb = 9,       flagAdhLow = 10,           flagDbToData = 11,
        flagDbToAcc = 12,      flagDbToSb = 13,           flagSbToX = 14,
        flagSbToY = 15,        flagSbToAlu = 16,          flagSbToDb = 17,
        flagSbToAdh = 18,      flagLoadDor = 19,          flagInBToDb = 20,
        flagInBToAdl = 21,     flagInAToSb = 22,          flagInAToLow = 23,
        flagLoadAlu = 24,      flagAluAdd = 25,           flagAluCarryHigh = 26,
        flagFreeCarryToAlu = 27, flagAluCarryToFreeCarry = 28, flagLoadInstruct = 29;

    // status byte bits
    localparam int statusC = 0;
    localparam int statusZ = 1;
    localparam int statusV = 6;
    localparam int statusN = 7;

    // register map
    localparam logic [1:0] regCmd = 2'd0;
    localparam logic [1:0] regStatus = 2'd1;
    localparam logic [1:0] regBusy = 2'd2;

    // flag groups that recur across steps
    localparam logic [numFlags-1:0] maskPcFetch = (1 << flagPcInc) | (1 << flagAdlToPcl)
        | (1 << flagAdhToPch) | (1 << flagLoadAbl) | (1 << flagLoadAbh);
    localparam logic [numFlags-1:0] maskDataToB = (1 << flagDbToData) | (1 << flagInBToDb);
    localparam logic [numFlags-1:0] maskAddX = maskDataToB | (1 << flagLoadAlu)
        | (1 << flagAluAdd) | (1 << flagSbToX) | (1 << flagInAToSb);
    localparam logic [numFlags-1:0] maskAddY = maskDataToB | (1 << flagLoadAlu)
        | (1 << flagAluAdd) | (1 << flagSbToY) | (1 << flagInAToSb);
    localparam logic [numFlags-1:0] maskZpAlu = (1 << flagAdhLow) | (1 << flagLoadAbh)
        | (1 << flagAdlToAlu) | (1 << flagLoadAbl);
    localparam logic [numFlags-1:0] maskZpData = (1 << flagAdhLow) | (1 << flagLoadAbh)
        | (1 << flagAdlToData) | (1 << flagLoadAbl);
    localparam logic [numFlags-1:0] maskHighData = (1 << flagAdhToData) | (1 << flagLoadAbh)
        | (1 << flagAdlToAlu) | (1 << flagLoadAbl);
    localparam logic [numFlags-1:0] maskIncAlu = (1 << flagInAToLow) | (1 << flagAluCarryHigh)
        | (1 << flagAluAdd) | (1 << flagLoadAlu);

endpackage

/* hw/ctrlRegs.sv */
`timescale 1ns/1ps

module ctrlRegs (
    input  logic clk,
    input  logic rst,
    input  logic wbCyc,
    input  logic wbStb,
    input  logic wbWe,
    input  logic [1:0] wbAdr,
    input  logic [cpuCtrlPkg::wbDataWidth-1:0] wbDatW,
    output logic [cpuCtrlPkg::wbDataWidth-1:0] wbDatR,
    output logic wbAck,
    input  logic busy,
    output logic start,
    output logic [cpuCtrlPkg::instrWidth-1:0] instr,
    output logic [cpuCtrlPkg::modeWidth-1:0] mode,
    output logic [7:0] status
);
    import cpuCtrlPkg::*;

    logic wrAccept;         // write request on its ack cycle
    logic [7:0] statusReg;  // host visible copy

    // one cycle ack, drops again even if stb is still held
    always_ff @(posedge clk) begin
        if (rst) begin
            wbAck <= 1'b0;
        end else begin
            wbAck <= wbCyc & wbStb & ~wbAck;
        end
    end

    assign wrAccept = wbAck & wbCyc & wbStb & wbWe;

    // command while busy is acked but ignored
    assign start = wrAccept & (wbAdr == regCmd) & ~busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            statusReg <= '0;
        end else if (wrAccept && wbAdr == regStatus) begin
            statusReg <= wbDatW[7:0];
        end
    end

    // snapshot for the sequence about to run,
    // later status writes only reach the next command
    always_ff @(posedge clk) begin
        if (start) begin
            instr <= wbDatW[instrWidth-1:0];
            mode <= wbDatW[8 +: modeWidth];
            status <= statusReg;
        end
    end

    always_comb begin
        wbDatR = '0;
        case (wbAdr)
            regStatus: begin
                wbDatR[7:0] = statusReg;
            end
            regBusy: begin
                wbDatR[0] = busy;
            end
            default: begin
                wbDatR = '0;  // cmd reads as zero
            end
        endcase
    end

endmodule

/* hw/stepTimer.sv */
`timescale 1ns/1ps

module stepTimer (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic passAddr,
    input  logic addrDone,
    input  logic opDone,
    output logic inAddr,
    output logic [cpuCtrlPkg::stepWidth-1:0] step,
    output logic busy
);

    logic addrPhase;  // addressing entered, bypass not yet applied

    // instr and mode load on the same edge as busy, so the bypass
    // decision is taken while the first step is already running
    assign inAddr = addrPhase & ~passAddr;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            addrPhase <= 1'b0;
            step <= '0;
        end else if (start) begin
            busy <= 1'b1;
            addrPhase <= 1'b1;
            step <= '0;
        end else if (inAddr) begin
            if (addrDone) begin
                addrPhase <= 1'b0;  // next is T0
                step <= '0;
            end else begin
                step <= step + 1'b1;
            end
        end else if (busy) begin
            // operation phase, also T0 of a bypassed mode
            addrPhase <= 1'b0;
            if (opDone) begin
                busy <= 1'b0;
                step <= '0;
            end else begin
                step <= step + 1'b1;
            end
        end
    end

endmodule

/* hw/addressingDecoder.sv */
`timescale 1ns/1ps

module addressingDecoder (
    input  logic [cpuCtrlPkg::instrWidth-1:0] instr,
    input  logic [cpuCtrlPkg::modeWidth-1:0] mode,
    input  logic inAddr,
    input  logic [cpuCtrlPkg::stepWidth-1:0] step,
    output logic passAddr,
    output logic addrDone,
    output logic [cpuCtrlPkg::numFlags-1:0] addrFlags
);
    import cpuCtrlPkg::*;

    logic isSta;
    logic isStx;
    logic isSty;
    logic xyStoreMode;  // X and Y can only be stored in these modes
    logic [stepWidth-1:0] lastStep;
    logic [numFlags-1:0] idxAdd;  // data + index register in the ALU
    logic [numFlags-1:0] stepFlags;

    assign isSta = (instr == instrSta);
    assign isStx = (instr == instrStx);
    assign isSty = (instr == instrSty);

    always_comb begin
        passAddr = 1'b0;
        lastStep = '0;
        xyStoreMode = 1'b0;
        case (mode)
            modeZpg: begin
                xyStoreMode = 1'b1;
            end
            modeAbs, modeZpgX, modeZpgY: begin
                lastStep = 2'd1;
                xyStoreMode = 1'b1;
            end
            modeAbsX, modeAbsY: lastStep = 2'd2;
            modeXind, modeIndY: lastStep = 2'd3;
            default: passAddr = 1'b1;  // imm, impl, acc, rel, unsupported ind
        endcase
    end

    assign addrDone = inAddr & (step == lastStep);
    assign idxAdd = (mode == modeAbsY || mode == modeZpgY) ? maskAddY : maskAddX;

    always_comb begin
        stepFlags = '0;
        case (mode)
            modeAbs: begin
                // low byte parked in B, then high byte straight from data
                stepFlags = (step == 2'd0) ? (maskPcFetch | maskDataToB) : maskHighData;
            end
            modeAbsX, modeAbsY: begin
                case (step)
                    2'd0: stepFlags = maskPcFetch | idxAdd;
                    2'd1: stepFlags = idxAdd | (1 << flagAdlToAlu) | (1 << flagLoadAbl);
                    default: begin
                        stepFlags = (1 << flagSbToAlu) | (1 << flagAdhToSb) | (1 << flagLoadAbh);
                    end
                endcase
            end
            modeXind: begin
                case (step)
                    2'd0: stepFlags = maskAddX | (1 << flagPcInc);
                    2'd1: begin  // pointer low, pointer + 1 through the ALU
                        stepFlags = maskZpAlu | maskIncAlu;
                        stepFlags[flagSbToAlu] = 1'b1;
                        stepFlags[flagDbToSb] = 1'b1;
                        stepFlags[flagInBToDb] = 1'b1;
                    end
                    2'd2: begin
                        stepFlags = maskZpAlu | maskDataToB | (1 << flagInAToLow);
                        stepFlags[flagLoadAlu] = 1'b1;
                        stepFlags[flagAluAdd] = 1'b1;
                    end
                    default: stepFlags = maskHighData;
                endcase
            end
            modeIndY: begin
                case (step)
                    2'd0: stepFlags = maskZpData | maskDataToB | maskIncAlu;
                    2'd1: stepFlags = maskZpAlu | maskAddY | (1 << flagFreeCarryToAlu);
                    2'd2: begin  // high byte plus carry out of low + Y
                        stepFlags = maskZpAlu | maskDataToB | (1 << flagInAToLow);
                        stepFlags[flagAluCarryToFreeCarry] = 1'b1;
                        stepFlags[flagLoadAlu] = 1'b1;
                        stepFlags[flagAluAdd] = 1'b1;
                    end
                    default: stepFlags = maskHighData;
                endcase
            end
            modeZpg: stepFlags = maskZpData;
            modeZpgX, modeZpgY: stepFlags = (step == 2'd0) ? idxAdd : maskZpAlu;
            default: stepFlags = '0;
        endcase
    end

    // stores put the register on the data bus in the last step
    always_comb begin
        addrFlags = '0;
        if (inAddr) begin
            addrFlags = stepFlags;
            if (addrDone && isSta) begin
                addrFlags[flagDbToAcc] = 1'b1;
                addrFlags[flagLoadDor] = 1'b1;
            end
            if (addrDone && xyStoreMode && (isStx || isSty)) begin
                addrFlags[flagDbToSb] = 1'b1;
                addrFlags[flagSbToX] = isStx;
                addrFlags[flagSbToY] = isSty;
                addrFlags[flagLoadDor] = 1'b1;
            end
        end
    end

endmodule

/* hw/branchDecoder.sv */
`timescale 1ns/1ps

module branchDecoder (
    input  logic clk,
    input  logic rst,
    input  logic [cpuCtrlPkg::instrWidth-1:0] instr,
    input  logic [7:0] status,
    input  logic freeCarry,
    input  logic inAddr,
    input  logic busy,
    input  logic [cpuCtrlPkg::stepWidth-1:0] step,
    output logic [cpuCtrlPkg::numFlags-1:0] opFlags,
    output logic opDone
);
    import cpuCtrlPkg::*;

    logic isBranch;
    logic taken;
    logic opPhase;
    logic pageCross;  // pcl + offset carried into pch
    logic [numFlags-1:0] fetchFlags;

    assign opPhase = busy & ~inAddr;
    assign fetchFlags = maskPcFetch | (1 << flagLoadInstruct);

    always_comb begin
        isBranch = 1'b1;
        case (instr)
            instrBcc: taken = ~status[statusC];
            instrBcs: taken = status[statusC];
            instrBeq: taken = status[statusZ];
            instrBne: taken = ~status[statusZ];
            instrBmi: taken = status[statusN];
            instrBpl: taken = ~status[statusN];
            instrBvc: taken = ~status[statusV];
            instrBvs: taken = status[statusV];
            default: begin
                isBranch = 1'b0;
                taken = 1'b0;
            end
        endcase
    end

    // carry of the T1 add, held for the T2 decision
    always_ff @(posedge clk) begin
        if (rst) begin
            pageCross <= 1'b0;
        end else if (opPhase && taken && step == 2'd1) begin
            pageCross <= freeCarry;
        end
    end

    always_comb begin
        opFlags = '0;
        if (opPhase && !isBranch) begin
            opFlags = fetchFlags;  // only the next opcode fetch
        end else if (opPhase) begin
            case (step)
                2'd0: begin  // offset + pcl in the ALU
                    opFlags = maskPcFetch | (1 << flagInBToAdl) | (1 << flagDbToData);
                    opFlags = opFlags | (1 << flagSbToDb) | (1 << flagInAToSb);
                    opFlags = opFlags | (1 << flagAluAdd) | (1 << flagLoadAlu);
                end
                2'd1: begin
                    if (taken) begin
                        opFlags = (1 << flagPcInc) | (1 << flagAdlToAlu) | (1 << flagAdhToPch);
                        opFlags = opFlags | (1 << flagLoadAbl) | (1 << flagLoadPc);
                        // pch + carry prepared
                        opFlags = opFlags | (1 << flagSbToAdh) | (1 << flagDbToSb);
                        opFlags = opFlags | (1 << flagInAToLow) | (1 << flagInBToDb);
                        opFlags[flagAluCarryToFreeCarry] = 1'b1;
                    end else begin
                        opFlags = fetchFlags;
                    end
                end
                2'd2: begin
                    if (pageCross) begin
                        opFlags = (1 << flagPcInc) | (1 << flagSbToAlu) | (1 << flagAdhToSb);
                        opFlags = opFlags | (1 << flagAdlToPcl) | (1 << flagLoadPc);
                    end else begin
                        opFlags = fetchFlags;
                    end
                end
                default: opFlags = fetchFlags;
            endcase
        end
    end

    assign opDone = opFlags[flagLoadInstruct];

endmodule

/* hw/cpuControl.sv */
`timescale 1ns/1ps

module cpuControl (
    input  logic clk,
    input  logic rst,
    input  logic wbCyc,
    input  logic wbStb,
    input  logic wbWe,
    input  logic [1:0] wbAdr,
    input  logic [cpuCtrlPkg::wbDataWidth-1:0] wbDatW,
    output logic [cpuCtrlPkg::wbDataWidth-1:0] wbDatR,
    output logic wbAck,
    input  logic freeCarry,
    output logic [cpuCtrlPkg::numFlags-1:0] ctrlFlags,
    output logic busy
);
    import cpuCtrlPkg::*;

    logic start;
    logic [instrWidth-1:0] instr;
    logic [modeWidth-1:0] mode;
    logic [7:0] status;
    logic inAddr;
    logic [stepWidth-1:0] step;
    logic passAddr;
    logic addrDone;
    logic opDone;
    logic [numFlags-1:0] addrFlags;
    logic [numFlags-1:0] opFlags;

    ctrlRegs i_ctrlRegs (.clk(clk), .rst(rst), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
        .wbAdr(wbAdr), .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck), .busy(busy),
        .start(start), .instr(instr), .mode(mode), .status(status));

    stepTimer i_stepTimer (.clk(clk), .rst(rst), .start(start), .passAddr(passAddr),
        .addrDone(addrDone), .opDone(opDone), .inAddr(inAddr), .step(step), .busy(busy));

    addressingDecoder i_addressingDecoder (.instr(instr), .mode(mode), .inAddr(inAddr),
        .step(step), .passAddr(passAddr), .addrDone(addrDone), .addrFlags(addrFlags));

    branchDecoder i_branchDecoder (.clk(clk), .rst(rst), .instr(instr), .status(status),
        .freeCarry(freeCarry), .inAddr(inAddr), .busy(busy), .step(step),
        .opFlags(opFlags), .opDone(opDone));

    assign ctrlFlags = addrFlags | opFlags;  // each side is zero outside its phase

endmodule

/* testbench/cpuControlTasks.svh */
task automatic checkValue(input string name, input logic [31:0] expected,
        input logic [31:0] actual);
    checkCount++;
    if (actual !== expected) begin
        errorCount++;
        $display("** Error at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
    end
endtask

function automatic logic [wbDataWidth-1:0] cmdWord(input logic [instrWidth-1:0] instr,
        input logic [modeWidth-1:0] mode);
    return {4'b0000, mode, 2'b00, instr};
endfunction

// number of addressing steps of a mode
function automatic int addrStepCount(input logic [modeWidth-1:0] mode);
    case (mode)
        modeZpg: return 1;
        modeAbs, modeZpgX, modeZpgY: return 2;
        modeAbsX, modeAbsY: return 3;
        modeXind, modeIndY: return 4;
        default: return 0;
    endcase
endfunction

function automatic logic branchTaken(input logic [instrWidth-1:0] instr, input logic [7:0] st);
    case (instr)
        instrBcc: return !st[statusC];
        instrBcs: return st[statusC];
        instrBeq: return st[statusZ];
        instrBne: return !st[statusZ];
        instrBmi: return st[statusN];
        instrBpl: return !st[statusN];
        instrBvc: return !st[statusV];
        default: return st[statusV];  // bvs
    endcase
endfunction

// request held until ack and dropped after the ack edge
task automatic wbTransfer(input logic we, input logic [1:0] adr,
        input logic [wbDataWidth-1:0] datW, output logic [wbDataWidth-1:0] datR);
    int waitCycles;
    waitCycles = 0;
    wbCyc = 1'b1;
    wbStb = 1'b1;
    wbWe = we;
    wbAdr = adr;
    wbDatW = datW;
    do begin
        @(posedge clk);
        #1;
        waitCycles++;
    end while (!wbAck && waitCycles < 16);
    if (!wbAck) begin
        errorCount++;
        $display("bus access to register %0d was never acknowledged", adr);
    end
    datR = wbDatR;
    @(posedge clk);  // request acted on here
    #1;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
endtask

task automatic wbWrite(input logic [1:0] adr, input logic [wbDataWidth-1:0] data);
    logic [wbDataWidth-1:0] ignored;
    wbTransfer(1'b1, adr, data, ignored);
endtask

task automatic wbRead(input logic [1:0] adr, output logic [wbDataWidth-1:0] data);
    wbTransfer(1'b0, adr, '0, data);
endtask

task automatic recordTrace();
    flagTrace.delete();
    while (busy && flagTrace.size() < 16) begin  // cap catches a stuck busy
        flagTrace.push_back(ctrlFlags);
        @(posedge clk);
        #1;
    end
endtask

task automatic runCommand(input logic [instrWidth-1:0] instr, input logic [modeWidth-1:0] mode);
    wbWrite(regCmd, cmdWord(instr, mode));
    recordTrace();
endtask

// trace length and fetch flag on the final step only
task automatic verifyLength(input int expLen);
    checkValue("busy cycles", 32'(expLen), 32'(flagTrace.size()));
    foreach (flagTrace[i]) begin
        checkValue("flagLoadInstruct", 32'(i == expLen - 1), 32'(flagTrace[i][flagLoadInstruct]));
    end
endtask

task automatic resetAndRegisters();
    logic [wbDataWidth-1:0] rdData;
    logic [7:0] st;
    checkValue("busy", 0, 32'(busy));
    checkValue("ctrlFlags", 0, ctrlFlags);
    checkValue("wbAck", 0, 32'(wbAck));
    st = 8'($random(seed));
    wbWrite(regStatus, {8'h00, st});
    wbRead(regStatus, rdData);
    checkValue("regStatus", 32'(st), 32'(rdData));
    wbRead(regBusy, rdData);
    checkValue("regBusy", 0, 32'(rdData));
endtask

task automatic loadTiming();
    int steps;
    int lowStep;
    for (int m = 0; m < 9; m++) begin
        steps = addrStepCount(keptModes[m]);
        runCommand(instrLda, keptModes[m]);
        verifyLength(steps + 1);
        if (steps > 0 && flagTrace.size() > steps) begin
            checkValue("flagLoadAbh", 1, 32'(flagTrace[steps - 1][flagLoadAbh]));
            // indexed absolute loads the low byte one step ahead of the carry
            lowStep = (keptModes[m] == modeAbsX || keptModes[m] == modeAbsY) ? steps - 2
                : steps - 1;
            checkValue("flagLoadAbl", 1, 32'(flagTrace[lowStep][flagLoadAbl]));
        end
    end
endtask

task automatic storeFlags();
    int steps;
    logic [instrWidth-1:0] ins;
    logic xyMode;
    logic isLast;
    for (int s = 0; s < 3; s++) begin
        for (int m = 0; m < 8; m++) begin
            ins = storeInstrs[s];
            steps = addrStepCount(keptModes[m]);
            xyMode = keptModes[m] == modeAbs || keptModes[m] == modeZpg
                || keptModes[m] == modeZpgX || keptModes[m] == modeZpgY;
            runCommand(ins, keptModes[m]);
            verifyLength(steps + 1);
            foreach (flagTrace[i]) begin
                isLast = (i == steps - 1);
                checkValue("flagLoadDor", 32'(isLast && (ins == instrSta || xyMode)),
                    32'(flagTrace[i][flagLoadDor]));
                if (isLast) begin
                    checkValue("flagDbToAcc", 32'(ins == instrSta),
                        32'(flagTrace[i][flagDbToAcc]));
                    checkValue("flagDbToSb", 32'(ins != instrSta && xyMode),
                        32'(flagTrace[i][flagDbToSb]));
                    checkValue("flagSbToX", 32'(ins == instrStx && xyMode),
                        32'(flagTrace[i][flagSbToX]));
                    checkValue("flagSbToY", 32'(ins == instrSty && xyMode),
                        32'(flagTrace[i][flagSbToY]));
                end
            end
        end
    end
endtask

task automatic branchPaths();
    logic [7:0] st;
    logic carry;
    logic taken;
    logic pcLoaded;
    for (int b = 0; b < 8; b++) begin
        for (int r = 0; r < branchRuns; r++) begin
            st = 8'($random(seed));
            carry = 1'($random(seed));
            taken = branchTaken(branchInstrs[b], st);
            wbWrite(regStatus, {8'h00, st});
            freeCarry = carry;  // held for the whole sequence
            runCommand(branchInstrs[b], modeRel);
            verifyLength(!taken ? 2 : (carry ? 4 : 3));
            pcLoaded = 1'b0;
            foreach (flagTrace[i]) begin
                pcLoaded = pcLoaded | flagTrace[i][flagLoadPc];
            end
            checkValue("flagLoadPc", 32'(taken), 32'(pcLoaded));
        end
    end
    freeCarry = 1'b0;
endtask

task automatic commandWhileBusy();
    int steps;
    steps = addrStepCount(modeXind);
    wbWrite(regCmd, cmdWord(instrLda, modeXind));
    fork
        recordTrace();
        begin
            @(posedge clk);
            #1;
            wbWrite(regCmd, cmdWord(instrSta, modeAbs));  // lands mid sequence
        end
    join
    verifyLength(steps + 1);
    if (flagTrace.size() > steps) begin
        checkValue("flagLoadAbl", 1, 32'(flagTrace[steps - 1][flagLoadAbl]));
        checkValue("flagLoadAbh", 1, 32'(flagTrace[steps - 1][flagLoadAbh]));
    end
    // the discarded store must leave no trace in the load
    foreach (flagTrace[i]) begin
        checkValue("flagLoadDor", 0, 32'(flagTrace[i][flagLoadDor]));
        checkValue("flagDbToAcc", 0, 32'(flagTrace[i][flagDbToAcc]));
    end
    repeat (8) begin
        checkValue("busy", 0, 32'(busy));
        @(posedge clk);
        #1;
    end
endtask

/* testbench/cpuControlTb.sv */
`timescale 1ns/1ps

module cpuControlTb;
    import cpuCtrlPkg::*;

    localparam int clkPeriod = 8;
    localparam int branchRuns = 6;  // random status and carry draws per branch
    // one slot of 40 cycles per command run
    localparam int numSequences = 1 + 9 + 24 + 8 * branchRuns + 1;

    localparam logic [modeWidth-1:0] keptModes [9] = '{modeAbs, modeAbsX, modeAbsY,
        modeXind, modeIndY, modeZpg, modeZpgX, modeZpgY, modeImm};
    localparam logic [instrWidth-1:0] storeInstrs [3] = '{instrSta, instrStx, instrSty};
    localparam logic [instrWidth-1:0] branchInstrs [8] = '{instrBcc, instrBcs, instrBeq,
        instrBne, instrBmi, instrBpl, instrBvc, instrBvs};

    logic clk;
    logic rst;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    logic [1:0] wbAdr;
    logic [wbDataWidth-1:0] wbDatW;
    logic [wbDataWidth-1:0] wbDatR;
    logic wbAck;
    logic freeCarry;
    logic [numFlags-1:0] ctrlFlags;
    logic busy;

    int errorCount;
    int checkCount;
    integer seed;
    logic [numFlags-1:0] flagTrace[$];  // ctrlFlags of each busy cycle

    cpuControl i_cpuControl (
        .clk(clk),
        .rst(rst),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbAdr(wbAdr),
        .wbDatW(wbDatW),
        .wbDatR(wbDatR),
        .wbAck(wbAck),
        .freeCarry(freeCarry),
        .ctrlFlags(ctrlFlags),
        .busy(busy)
    );

    `include "cpuControlTasks.svh"

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    initial begin
        rst = 1'b1;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = '0;
        wbDatW = '0;
        freeCarry = 1'b0;
        errorCount = 0;
        checkCount = 0;
        seed = 32'h4176_d3d2;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;  // from here on every task starts 1 ns after an edge

        resetAndRegisters();
        loadTiming();
        storeFlags();
        branchPaths();
        commandWhileBusy();

        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(numSequences * 40 * clkPeriod);
        $display("watchdog expired at %0t, a bus access or sequence never ended", $time);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+testbench
hw/cpuCtrlPkg.sv
hw/ctrlRegs.sv
hw/stepTimer.sv
hw/addressingDecoder.sv
hw/branchDecoder.sv
hw/cpuControl.sv
testbench/cpuControlTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing -j 0
TOP = cpuControlTb
FILELIST = vlog.f
OBJDIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

# fails unless the pass message shows up on a line of its own
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJDIR)
